// ==== compile.f ====
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core_top.sv
verif/rv_core_sva.sv
verif/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_regfile.sv
  - source/rv_decode.sv
  - source/rv_execute.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_sva.sv
      - verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

    typedef struct {
        logic [xlen-1:0]     word;
        logic [xlen-1:0]     pc;
        logic [tag_bits-1:0] tag;
        int                  cycle;
        int                  stalls;
        logic                dropped;
    } entry_t;

    logic                     clk_i;
    logic                     rstn_i;
    logic [xlen-1:0]          instr_i;
    logic [xlen-1:0]          pc_i;
    logic                     instr_valid_i;
    logic                     flush_i;
    logic                     stall_o;
    logic                     retire_ready_i;
    logic                     retire_valid_o;
    logic [tag_bits-1:0]      retire_tag_o;
    logic [reg_addr_bits-1:0] retire_rd_o;
    logic [xlen-1:0]          retire_data_o;
    logic                     retire_illegal_o;

    logic [31:0]         lfsr;
    logic [xlen-1:0]     model_regs [num_regs];
    entry_t              pending [$];  // accepted and not yet retired, oldest first
    logic [tag_bits-1:0] next_tag;
    logic                offered_taken;
    logic                dec_full;     // model of the decode register
    logic                ex_full;      // model of the result register
    int cycle;
    int stall_edges;
    int stall_run;
    int retired_count;
    int value_errors;
    int other_errors;

    rv_core_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        else return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        value_errors++;
        $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("Problem at %0t: %s", $time, msg);
    endtask

    // sequential reference for one word, x0 in the model is never written
    function automatic void model_exec(input logic [31:0] w, input logic [31:0] pc,
                                       output logic [31:0] data, output logic illegal);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] upper;
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        upper   = {w[31:12], 12'h000};
        illegal = 1'b0;
        data    = 32'h0;
        case (w[6:0])
            7'h33: begin
                if (w[31:25] == 7'h00 && w[14:12] == 3'h0) data = a + b;
                else if (w[31:25] == 7'h20 && w[14:12] == 3'h0) data = a - b;
                else if (w[31:25] == 7'h00 && w[14:12] == 3'h7) data = a & b;
                else if (w[31:25] == 7'h00 && w[14:12] == 3'h6) data = a | b;
                else if (w[31:25] == 7'h00 && w[14:12] == 3'h4) data = a ^ b;
                else illegal = 1'b1;
            end
            7'h13: begin
                if (w[14:12] == 3'h0) data = a + {{20{w[31]}}, w[31:20]};
                else illegal = 1'b1;
            end
            7'h37:   data = upper;
            7'h17:   data = pc + upper;
            default: illegal = 1'b1;
        endcase
    endfunction

    task automatic make_instr;
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] word;
        take_bits(4, kind);
        take_bits(3, rd);  // small register range keeps dependencies frequent
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(20, imm);
        case (kind)
            0: word = {7'h00, rs2[4:0], rs1[4:0], 3'h0, rd[4:0], 7'h33};
            1: word = {7'h20, rs2[4:0], rs1[4:0], 3'h0, rd[4:0], 7'h33};
            2: word = {7'h00, rs2[4:0], rs1[4:0], 3'h7, rd[4:0], 7'h33};
            3: word = {7'h00, rs2[4:0], rs1[4:0], 3'h6, rd[4:0], 7'h33};
            4: word = {7'h00, rs2[4:0], rs1[4:0], 3'h4, rd[4:0], 7'h33};
            7: word = {imm[19:0], rd[4:0], 7'h37};
            8: word = {imm[19:0], rd[4:0], 7'h17};
            9: take_bits(32, word);  // mostly outside the subset
            default: word = {imm[11:0], rs1[4:0], 3'h0, rd[4:0], 7'h13};
        endcase
        instr_i = word;
        pc_i    = pc_i + 32'd4;
    endtask

    task automatic check_retire;
        entry_t      e;
        logic [31:0] exp_data;
        logic        exp_illegal;
        logic [4:0]  exp_rd;
        while (pending.size() > 0 && pending[0].dropped) begin
            void'(pending.pop_front());
        end
        if (pending.size() == 0) begin
            report_problem($sformatf("tag %0d retired with nothing queued", retire_tag_o));
        end else begin
            e = pending.pop_front();
            model_exec(e.word, e.pc, exp_data, exp_illegal);
            exp_rd = e.word[11:7];
            if (retire_tag_o !== e.tag) report_mismatch("retire_tag_o", e.tag, retire_tag_o);
            if (retire_rd_o !== exp_rd) report_mismatch("retire_rd_o", exp_rd, retire_rd_o);
            if (retire_illegal_o !== exp_illegal) begin
                report_mismatch("retire_illegal_o", exp_illegal, retire_illegal_o);
            end
            if (retire_data_o !== exp_data) report_mismatch("retire_data_o", exp_data, retire_data_o);
            // two edges from acceptance plus one per frozen edge
            if (cycle != e.cycle + 2 + stall_edges - e.stalls) begin
                report_mismatch("retire_valid_o latency", e.cycle + 2 + stall_edges - e.stalls,
                                cycle);
            end
            if (!exp_illegal && exp_rd != 5'd0) model_regs[exp_rd] = exp_data;
            retired_count++;
        end
    endtask

    // called between edges and describes what the next rising edge does
    task automatic check_edge;
        logic exp_stall;
        logic accepted;
        exp_stall = ex_full && !retire_ready_i;
        accepted  = instr_valid_i && !stall_o && !flush_i;
        if (retire_valid_o !== ex_full) report_mismatch("retire_valid_o", ex_full, retire_valid_o);
        if (stall_o !== exp_stall) report_mismatch("stall_o", exp_stall, stall_o);
        if (retire_valid_o && retire_ready_i) check_retire();
        if (exp_stall && flush_i && dec_full && pending.size() > 0) begin
            pending[$].dropped = 1'b1;  // the frozen decode entry is the youngest one
        end
        if (accepted) begin
            pending.push_back('{instr_i, pc_i, next_tag, cycle, stall_edges, 1'b0});
            next_tag++;
            offered_taken = 1'b1;
        end
        if (!exp_stall) begin
            ex_full  = dec_full;
            dec_full = accepted;
        end else if (flush_i) begin
            dec_full = 1'b0;
        end
        if (stall_o) begin
            stall_edges++;
            stall_run++;
        end else begin
            stall_run = 0;
        end
        cycle++;
    endtask

    task automatic drive_inputs;
        logic [31:0] bits;
        if (offered_taken) begin  // fetch holds the word until it is accepted
            make_instr();
            offered_taken = 1'b0;
        end
        take_bits(2, bits);
        instr_valid_i = (bits != 0);
        take_bits(2, bits);
        retire_ready_i = (bits != 0);
        take_bits(5, bits);
        flush_i = (bits == 0);
    endtask

    initial begin
        int n;
        int wait_cycles;
        int sva_errors;
        rstn_i         = 1'b0;
        instr_i        = '0;
        pc_i           = 32'h0000_1000;
        instr_valid_i  = 1'b0;
        flush_i        = 1'b0;
        retire_ready_i = 1'b1;
        lfsr           = 32'h906d_cb84;
        next_tag       = '0;
        offered_taken  = 1'b1;
        dec_full       = 1'b0;
        ex_full        = 1'b0;
        cycle          = 0;
        stall_edges    = 0;
        stall_run      = 0;
        retired_count  = 0;
        value_errors   = 0;
        other_errors   = 0;
        for (n = 0; n < num_regs; n++) begin
            model_regs[n] = '0;
        end

        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        drive_inputs();
        @(negedge clk_i);
        if (retire_valid_o !== 1'b0 || stall_o !== 1'b0) report_problem("not idle after reset");

        for (n = 0; n < 3000; n++) begin
            if (n > 0) @(negedge clk_i);
            check_edge();
            @(posedge clk_i);
            #1;
            drive_inputs();
            if (stall_run > 40) begin
                report_problem("Timeout: stall_o stayed high for over 40 cycles");
                break;
            end
        end

        instr_valid_i  = 1'b0;
        flush_i        = 1'b0;
        retire_ready_i = 1'b1;
        wait_cycles    = 0;
        @(negedge clk_i);
        while ((retire_valid_o || dec_full || ex_full) && wait_cycles < 20) begin
            check_edge();
            @(posedge clk_i);
            @(negedge clk_i);
            wait_cycles++;
        end
        if (retire_valid_o || dec_full || ex_full) begin
            report_problem("Timeout: pipeline did not drain in 20 cycles");
        end

        foreach (pending[i]) begin
            if (!pending[i].dropped) begin
                report_problem($sformatf("tag %0d never retired", pending[i].tag));
            end
        end
        if (retired_count < 100) report_problem("too few instructions retired");

        sva_errors = u_dut.u_execute.u_sva.fail_count;
        $display("retired %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 retired_count, value_errors, other_errors, sva_errors);
        if (value_errors == 0 && other_errors == 0 && sva_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/rv_core_sva.sv ====
`timescale 1ns/1ps

module rv_core_sva import rv_pkg::*; (
    input logic                     clk_i,
    input logic                     rstn_i,
    input logic                     retire_ready_i,
    input logic                     retire_valid_o,
    input logic [tag_bits-1:0]      retire_tag_o,
    input logic [reg_addr_bits-1:0] retire_rd_o,
    input logic [xlen-1:0]          retire_data_o,
    input logic                     retire_illegal_o,
    input logic                     ret_rd_wr
);

    int fail_count = 0;  // read by the testbench at the end of the run

    // a held result must not move until it is consumed
    hold_under_backpressure: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_tag_o)
            && $stable(retire_rd_o) && $stable(retire_data_o) && $stable(retire_illegal_o))
    else begin
        fail_count++;
        $error("retire outputs changed while retire_ready_i was low");
    end

    // an illegal word must arrive from decode with its register write already cleared
    no_write_when_illegal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o && retire_illegal_o |-> !ret_rd_wr)
    else begin
        fail_count++;
        $error("register write enabled for an illegal instruction");
    end

    idle_after_reset: assert property (@(posedge clk_i) !rstn_i |=> !retire_valid_o)
    else begin
        fail_count++;
        $error("retire_valid_o high in the cycle after reset");
    end

endmodule

bind rv_execute rv_core_sva u_sva (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .retire_ready_i   (retire_ready_i),
    .retire_valid_o   (retire_valid_o),
    .retire_tag_o     (retire_tag_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o),
    .ret_rd_wr        (ret_rd_wr)
);

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [xlen-1:0]          instr_i,
    input  logic [xlen-1:0]          pc_i,
    input  logic                     instr_valid_i,
    input  logic                     flush_i,
    output logic                     stall_o,

    input  logic                     retire_ready_i,
    output logic                     retire_valid_o,
    output logic [tag_bits-1:0]      retire_tag_o,
    output logic [reg_addr_bits-1:0] retire_rd_o,
    output logic [xlen-1:0]          retire_data_o,
    output logic                     retire_illegal_o
);

    logic                     dec_valid;
    logic [tag_bits-1:0]      dec_tag;
    logic [xlen-1:0]          dec_pc;
    logic [reg_addr_bits-1:0] dec_rs1;
    logic [reg_addr_bits-1:0] dec_rs2;
    logic [reg_addr_bits-1:0] dec_rd;
    logic                     dec_rd_wr;
    logic [alu_op_bits-1:0]   dec_alu_op;
    logic                     dec_opa_sel;
    logic                     dec_opb_sel;
    logic [xlen-1:0]          dec_imm;
    logic                     dec_illegal;

    logic [reg_addr_bits-1:0] rf_raddr_a;
    logic [reg_addr_bits-1:0] rf_raddr_b;
    logic [xlen-1:0]          rf_rdata_a;
    logic [xlen-1:0]          rf_rdata_b;
    logic                     rf_we;
    logic [reg_addr_bits-1:0] rf_waddr;
    logic [xlen-1:0]          rf_wdata;

    assign stall_o = retire_valid_o && !retire_ready_i;  // freezes both stages

    rv_decode u_decode (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .valid_i       (instr_valid_i),
        .flush_i       (flush_i),
        .stall_i       (stall_o),
        .dec_valid_o   (dec_valid),
        .dec_tag_o     (dec_tag),
        .dec_pc_o      (dec_pc),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2),
        .dec_rd_o      (dec_rd),
        .dec_rd_wr_o   (dec_rd_wr),
        .dec_alu_op_o  (dec_alu_op),
        .dec_opa_sel_o (dec_opa_sel),
        .dec_opb_sel_o (dec_opb_sel),
        .dec_imm_o     (dec_imm),
        .dec_illegal_o (dec_illegal)
    );

    rv_execute u_execute (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_o),
        .dec_valid_i      (dec_valid),
        .dec_tag_i        (dec_tag),
        .dec_pc_i         (dec_pc),
        .dec_rs1_i        (dec_rs1),
        .dec_rs2_i        (dec_rs2),
        .dec_rd_i         (dec_rd),
        .dec_rd_wr_i      (dec_rd_wr),
        .dec_alu_op_i     (dec_alu_op),
        .dec_opa_sel_i    (dec_opa_sel),
        .dec_opb_sel_i    (dec_opb_sel),
        .dec_imm_i        (dec_imm),
        .dec_illegal_i    (dec_illegal),
        .rf_raddr_a_o     (rf_raddr_a),
        .rf_raddr_b_o     (rf_raddr_b),
        .rf_rdata_a_i     (rf_rdata_a),
        .rf_rdata_b_i     (rf_rdata_b),
        .rf_we_o          (rf_we),
        .rf_waddr_o       (rf_waddr),
        .rf_wdata_o       (rf_wdata),
        .retire_ready_i   (retire_ready_i),
        .retire_valid_o   (retire_valid_o),
        .retire_tag_o     (retire_tag_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o),
        .retire_illegal_o (retire_illegal_o)
    );

    rv_regfile u_regfile (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     stall_i,

    input  logic                     dec_valid_i,
    input  logic [tag_bits-1:0]      dec_tag_i,
    input  logic [xlen-1:0]          dec_pc_i,
    input  logic [reg_addr_bits-1:0] dec_rs1_i,
    input  logic [reg_addr_bits-1:0] dec_rs2_i,
    input  logic [reg_addr_bits-1:0] dec_rd_i,
    input  logic                     dec_rd_wr_i,
    input  logic [alu_op_bits-1:0]   dec_alu_op_i,
    input  logic                     dec_opa_sel_i,
    input  logic                     dec_opb_sel_i,
    input  logic [xlen-1:0]          dec_imm_i,
    input  logic                     dec_illegal_i,

    output logic [reg_addr_bits-1:0] rf_raddr_a_o,
    output logic [reg_addr_bits-1:0] rf_raddr_b_o,
    input  logic [xlen-1:0]          rf_rdata_a_i,
    input  logic [xlen-1:0]          rf_rdata_b_i,

    output logic                     rf_we_o,
    output logic [reg_addr_bits-1:0] rf_waddr_o,
    output logic [xlen-1:0]          rf_wdata_o,

    input  logic                     retire_ready_i,
    output logic                     retire_valid_o,
    output logic [tag_bits-1:0]      retire_tag_o,
    output logic [reg_addr_bits-1:0] retire_rd_o,
    output logic [xlen-1:0]          retire_data_o,
    output logic                     retire_illegal_o
);

    logic            ret_rd_wr;
    logic            pending_wr;
    logic            fwd_a;
    logic            fwd_b;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_res;

    assign rf_raddr_a_o = dec_rs1_i;
    assign rf_raddr_b_o = dec_rs2_i;

    // the held result has not reached the register file yet
    // x0 is excluded so a discarded write never leaks into a read
    assign pending_wr = retire_valid_o && ret_rd_wr && retire_rd_o != '0;
    assign fwd_a      = pending_wr && retire_rd_o == dec_rs1_i;
    assign fwd_b      = pending_wr && retire_rd_o == dec_rs2_i;

    assign rs1_val = fwd_a ? retire_data_o : rf_rdata_a_i;
    assign rs2_val = fwd_b ? retire_data_o : rf_rdata_b_i;

    assign opa = (dec_opa_sel_i == opa_pc) ? dec_pc_i : rs1_val;
    assign opb = (dec_opb_sel_i == opb_imm) ? dec_imm_i : rs2_val;

    always_comb begin
        case (dec_alu_op_i)
            alu_add:    alu_res = opa + opb;
            alu_sub:    alu_res = opa - opb;
            alu_and:    alu_res = opa & opb;
            alu_or:     alu_res = opa | opb;
            alu_xor:    alu_res = opa ^ opb;
            alu_pass_b: alu_res = opb;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            retire_valid_o <= 1'b0;
        end else if (!stall_i) begin
            retire_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            retire_tag_o     <= dec_tag_i;
            retire_rd_o      <= dec_rd_i;
            ret_rd_wr        <= dec_rd_wr_i;
            retire_illegal_o <= dec_illegal_i;
            retire_data_o    <= dec_illegal_i ? '0 : alu_res;
        end
    end

    // write-back happens on the same edge the result is consumed
    assign rf_we_o    = retire_valid_o && retire_ready_i && ret_rd_wr && !retire_illegal_o;
    assign rf_waddr_o = retire_rd_o;
    assign rf_wdata_o = retire_data_o;

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [xlen-1:0]          instr_i,
    input  logic [xlen-1:0]          pc_i,
    input  logic                     valid_i,
    input  logic                     flush_i,
    input  logic                     stall_i,

    output logic                     dec_valid_o,
    output logic [tag_bits-1:0]      dec_tag_o,
    output logic [xlen-1:0]          dec_pc_o,
    output logic [reg_addr_bits-1:0] dec_rs1_o,
    output logic [reg_addr_bits-1:0] dec_rs2_o,
    output logic [reg_addr_bits-1:0] dec_rd_o,
    output logic                     dec_rd_wr_o,
    output logic [alu_op_bits-1:0]   dec_alu_op_o,
    output logic                     dec_opa_sel_o,
    output logic                     dec_opb_sel_o,
    output logic [xlen-1:0]          dec_imm_o,
    output logic                     dec_illegal_o
);

    logic                   accept;
    logic [tag_bits-1:0]    tag_q;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;

    logic [alu_op_bits-1:0] alu_op_d;
    logic                   opa_sel_d;
    logic                   opb_sel_d;
    logic [xlen-1:0]        imm_d;
    logic                   rd_wr_d;
    logic                   illegal_d;

    assign accept = valid_i && !stall_i && !flush_i;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // anything not matched below stays illegal and writes nothing
        alu_op_d  = alu_pass_b;
        opa_sel_d = opa_rs1;
        opb_sel_d = opb_rs2;
        imm_d     = '0;
        rd_wr_d   = 1'b0;
        illegal_d = 1'b1;

        case (opcode)
            op_reg: begin
                rd_wr_d   = 1'b1;
                illegal_d = 1'b0;
                if (funct7 == f7_sub && funct3 == f3_add_sub) begin
                    alu_op_d = alu_sub;
                end else if (funct7 == f7_base && funct3 == f3_add_sub) begin
                    alu_op_d = alu_add;
                end else if (funct7 == f7_base && funct3 == f3_and) begin
                    alu_op_d = alu_and;
                end else if (funct7 == f7_base && funct3 == f3_or) begin
                    alu_op_d = alu_or;
                end else if (funct7 == f7_base && funct3 == f3_xor) begin
                    alu_op_d = alu_xor;
                end else begin
                    rd_wr_d   = 1'b0;
                    illegal_d = 1'b1;
                end
            end
            op_imm: begin
                if (funct3 == f3_add_sub) begin  // only addi from this group
                    alu_op_d  = alu_add;
                    opb_sel_d = opb_imm;
                    imm_d     = {{(xlen-12){instr_i[31]}}, instr_i[31:20]};
                    rd_wr_d   = 1'b1;
                    illegal_d = 1'b0;
                end
            end
            op_lui: begin
                alu_op_d  = alu_pass_b;
                opb_sel_d = opb_imm;
                imm_d     = {instr_i[31:12], 12'b0};
                rd_wr_d   = 1'b1;
                illegal_d = 1'b0;
            end
            op_auipc: begin
                alu_op_d  = alu_add;
                opa_sel_d = opa_pc;
                opb_sel_d = opb_imm;
                imm_d     = {instr_i[31:12], 12'b0};
                rd_wr_d   = 1'b1;
                illegal_d = 1'b0;
            end
            default: ;
        endcase
    end

    // valid and tag counter, flush drops whatever sits in the register
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            dec_valid_o <= 1'b0;
            tag_q       <= '0;
        end else begin
            if (!stall_i || flush_i) dec_valid_o <= accept;
            if (accept) tag_q <= tag_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dec_tag_o     <= tag_q;
            dec_pc_o      <= pc_i;
            dec_rs1_o     <= instr_i[19:15];
            dec_rs2_o     <= instr_i[24:20];
            dec_rd_o      <= instr_i[11:7];
            dec_rd_wr_o   <= rd_wr_d;
            dec_alu_op_o  <= alu_op_d;
            dec_opa_sel_o <= opa_sel_d;
            dec_opb_sel_o <= opb_sel_d;
            dec_imm_o     <= imm_d;
            dec_illegal_o <= illegal_d;
        end
    end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [reg_addr_bits-1:0] raddr_a_i,
    input  logic [reg_addr_bits-1:0] raddr_b_i,
    output logic [xlen-1:0]          rdata_a_o,
    output logic [xlen-1:0]          rdata_b_o,

    input  logic                     we_i,
    input  logic [reg_addr_bits-1:0] waddr_i,
    input  logic [xlen-1:0]          wdata_i
);

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // x0 is never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // reads see the old value during a write, execute forwards around it
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    // datapath and instruction width
    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;
    localparam int num_regs      = 1 << reg_addr_bits;
    localparam int tag_bits      = 4;  // sequence tag, wraps

    // major opcodes of the executed subset
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    // funct3 values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 values, only sub sets bit 30
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // alu operation codes
    localparam int alu_op_bits = 3;

    localparam logic [alu_op_bits-1:0] alu_add    = 3'd0;
    localparam logic [alu_op_bits-1:0] alu_sub    = 3'd1;
    localparam logic [alu_op_bits-1:0] alu_and    = 3'd2;
    localparam logic [alu_op_bits-1:0] alu_or     = 3'd3;
    localparam logic [alu_op_bits-1:0] alu_xor    = 3'd4;
    localparam logic [alu_op_bits-1:0] alu_pass_b = 3'd5;  // lui passes the immediate

    // operand a source
    localparam logic opa_rs1 = 1'b0;
    localparam logic opa_pc  = 1'b1;

    // operand b source
    localparam logic opb_rs2 = 1'b0;
    localparam logic opb_imm = 1'b1;

endpackage
